// ==== files.f ====
+incdir+include
hdl/merge_pkg.sv
hdl/frame_ctrl.sv
hdl/input_stage.sv
hdl/rr_arbiter.sv
hdl/frame_fifo.sv
hdl/frame_merger.sv
bench/merger_sva.sv
bench/merger_tb.sv

// ==== Makefile ====
TOP := merger_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

lint:
	verilator --lint-only -Wall +incdir+include \
		hdl/merge_pkg.sv hdl/frame_ctrl.sv hdl/input_stage.sv \
		hdl/rr_arbiter.sv hdl/frame_fifo.sv hdl/frame_merger.sv \
		--top-module frame_merger

clean:
	rm -rf obj_dir sim.log

// ==== bench/merger_tb.sv ====
`timescale 1ns/1ps
`include "merge_config.svh"

module merger_tb;

  localparam int NUM_FRAMES   = 12;
  localparam int FRAME_CYCLES = 30;   // generous bound per frame
  localparam int TIMEOUT      = (NUM_FRAMES + 1) * FRAME_CYCLES + 100;
  localparam int MAX_WORDS    = 6;
  localparam int W            = `MERGE_DATA_WIDTH;
  localparam logic [31:0] SEED = 32'd90;

  logic         clk;
  logic         nreset;
  logic         proc_req;
  logic         proc_req_in0_en;
  logic         proc_req_in1_en;
  logic         proc_ack;
  logic         in0_valid;
  logic         in0_ready;
  logic [W-1:0] in0_data;
  logic         in0_data_last;
  logic         in1_valid;
  logic         in1_ready;
  logic [W-1:0] in1_data;
  logic         in1_data_last;
  logic         out_valid;
  logic         out_ready;
  logic [W-1:0] out_data;
  logic         out_data_source_id;
  logic         out_data_last;

  // stimulus tables for the current frame
  int           word_cnt [2];
  int           gap_tab  [2][MAX_WORDS];    // idle cycles before each word
  logic [W-1:0] word_tab [2][MAX_WORDS];

  // reference model state
  logic [W-1:0] q0[$];                      // words taken from input 0, not yet out
  logic [W-1:0] q1[$];
  logic         src_log[$];                 // source IDs seen in this frame
  logic [1:0]   cur_en;
  int           frame_total;                // words expected at the output
  int           sent_cnt;
  int           ack_due;                    // countdown to the proc_ack rise
  int           cycle_cnt;
  logic [31:0]  stim_state;
  logic [31:0]  rdy_state;
  logic         ready_always;               // directed frame, no back-pressure
  string        test_name;

  frame_merger frame_merger_inst
  (
    .clk                (clk),
    .nreset             (nreset),
    .proc_req           (proc_req),
    .proc_req_in0_en    (proc_req_in0_en),
    .proc_req_in1_en    (proc_req_in1_en),
    .proc_ack           (proc_ack),
    .in0_valid          (in0_valid),
    .in0_ready          (in0_ready),
    .in0_data           (in0_data),
    .in0_data_last      (in0_data_last),
    .in1_valid          (in1_valid),
    .in1_ready          (in1_ready),
    .in1_data           (in1_data),
    .in1_data_last      (in1_data_last),
    .out_valid          (out_valid),
    .out_ready          (out_ready),
    .out_data           (out_data),
    .out_data_source_id (out_data_source_id),
    .out_data_last      (out_data_last)
  );

  bind frame_merger merger_sva merger_sva_inst
  (
    .clk                (clk),
    .nreset             (nreset),
    .proc_req           (proc_req),
    .proc_ack           (proc_ack),
    .in0_ready          (in0_ready),
    .in1_ready          (in1_ready),
    .out_valid          (out_valid),
    .out_ready          (out_ready),
    .out_data_last      (out_data_last),
    .out_data_source_id (out_data_source_id),
    .out_data           (out_data)
  );

  always #50 clk = ~clk;                    // 100 ns period

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw_random(output logic [31:0] r);
    stim_state = xorshift32(stim_state);
    r = stim_state;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR %s: %s", test_name, msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("MISMATCH %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    assert (act === exp) else report_mismatch(what, 32'(exp), 32'(act));
  endtask

  function automatic logic ready_of(input int port);
    return (port == 0) ? in0_ready : in1_ready;
  endfunction

  task automatic set_input(input int port, input logic v, input logic [W-1:0] d,
                           input logic l);
    if (port == 0)
    begin
      in0_valid     = v;
      in0_data      = d;
      in0_data_last = l;
    end
    else
    begin
      in1_valid     = v;
      in1_data      = d;
      in1_data_last = l;
    end
  endtask

  // one source, holds each word until it is taken
  task automatic drive_input(input int port);
    int k;
    for (k = 0; k < word_cnt[port]; k++)
    begin
      repeat (gap_tab[port][k])
      begin
        @(posedge clk);
        #1;
      end
      set_input(port, 1'b1, word_tab[port][k], k == word_cnt[port] - 1);
      do
        @(posedge clk);
      while (!ready_of(port));
      #1;
      set_input(port, 1'b0, '0, 1'b0);
    end
  endtask

  task automatic plan_frame(input logic [1:0] en, input bit directed);
    logic [31:0] r;
    int          p;
    int          k;
    for (p = 0; p < 2; p++)
    begin
      draw_random(r);
      if (directed)
        word_cnt[p] = (p == 0) ? 4 : 6;          // input 1 runs longer
      else if (en[p])
        word_cnt[p] = 1 + int'(r % 6);
      else
        word_cnt[p] = 0;
      for (k = 0; k < MAX_WORDS; k++)
      begin
        draw_random(r);
        word_tab[p][k] = r[W-1:0];
        gap_tab[p][k]  = directed ? 0 : int'(r[31:24] % 3);
      end
    end
  endtask

  // --------------------------------------------------
  // one request/acknowledge frame
  // --------------------------------------------------
  task automatic run_frame(input logic [1:0] en);
    logic [31:0] r;
    frame_total = word_cnt[0] + word_cnt[1];
    sent_cnt    = 0;
    src_log.delete();
    @(posedge clk);
    #1;
    cur_en          = en;
    proc_req        = 1'b1;
    proc_req_in0_en = en[0];
    proc_req_in1_en = en[1];
    draw_random(r);
    if (!en[0])
      set_input(0, 1'b1, r[W-1:0], 1'b0);        // offered but must never be taken
    if (!en[1])
      set_input(1, 1'b1, r[W+7:8], 1'b0);
    if (frame_total == 0)
    begin
      repeat (2)
      begin
        @(posedge clk);
        check_bit("proc_ack before empty frame ack", 1'b0, proc_ack);
      end
      @(posedge clk);
      check_bit("proc_ack for empty frame", 1'b1, proc_ack);
    end
    else
    begin
      fork
        if (en[0]) drive_input(0);
        if (en[1]) drive_input(1);
      join
      do
        @(posedge clk);
      while (!proc_ack);
    end
    #1;
    assert (sent_cnt == frame_total)
      else report_mismatch("output word count", frame_total, sent_cnt);
    assert (q0.size() == 0) else report_mismatch("input 0 words left", 0, q0.size());
    assert (q1.size() == 0) else report_mismatch("input 1 words left", 0, q1.size());
    proc_req = 1'b0;
    set_input(0, 1'b0, '0, 1'b0);
    set_input(1, 1'b0, '0, 1'b0);
    @(posedge clk);
    check_bit("proc_ack held one cycle after release", 1'b1, proc_ack);
    @(posedge clk);
    check_bit("proc_ack low after release", 1'b0, proc_ack);
  endtask

  task automatic check_alternation();
    int   i;
    logic exp_src;
    for (i = 0; i < src_log.size(); i++)
    begin
      if (i < 2 * word_cnt[0])
        exp_src = i[0];                          // 0, 1, 0, 1 while both still send
      else
        exp_src = 1'b1;                          // only input 1 is left
      assert (src_log[i] == exp_src)
        else report_mismatch($sformatf("source id of word %0d", i), 32'(exp_src),
                             32'(src_log[i]));
    end
  endtask

  // --------------------------------------------------
  // reference model and output checks
  // --------------------------------------------------
  always @(posedge clk)
  begin : model
    logic [W-1:0] exp_word;
    logic         exp_last;
    if (nreset)
    begin
      if (ack_due == 2)
        check_bit("proc_ack before rise", 1'b0, proc_ack);
      if (ack_due == 1)
        check_bit("proc_ack after final word", 1'b1, proc_ack);
      if (ack_due > 0)
        ack_due--;
      if (in0_valid && in0_ready)
        q0.push_back(in0_data);
      if (in1_valid && in1_ready)
        q1.push_back(in1_data);
      if (!cur_en[0])
        check_bit("in0_ready on disabled input", 1'b0, in0_ready);
      if (!cur_en[1])
        check_bit("in1_ready on disabled input", 1'b0, in1_ready);
      assert (!(proc_ack && sent_cnt < frame_total))
        else report_error("proc_ack high while words are outstanding");
      assert (!(out_valid && sent_cnt >= frame_total))
        else report_error("out_valid high with no word outstanding");
      if (out_valid && out_ready)
      begin
        if (out_data_source_id)
        begin
          assert (q1.size() != 0) else report_error("output word never sent on input 1");
          exp_word = q1.pop_front();
        end
        else
        begin
          assert (q0.size() != 0) else report_error("output word never sent on input 0");
          exp_word = q0.pop_front();
        end
        exp_last = (sent_cnt == frame_total - 1);
        assert (out_data == exp_word) else report_mismatch("out_data", 32'(exp_word),
                                                           32'(out_data));
        check_bit("out_data_last", exp_last, out_data_last);
        src_log.push_back(out_data_source_id);
        sent_cnt++;
        if (exp_last)
          ack_due = 2;                           // ack seen two edges later
      end
    end
  end

  // out_ready pattern, high about 70% of cycles
  always @(posedge clk)
  begin
    #1;
    rdy_state = xorshift32(rdy_state);
    out_ready = ready_always || (rdy_state % 10 < 7);
  end

  always @(posedge clk)
  begin
    cycle_cnt++;
    assert (cycle_cnt < TIMEOUT)
      else report_error($sformatf("run did not finish within %0d cycles", TIMEOUT));
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial
  begin : main
    logic [31:0] r;
    logic [1:0]  en;
    int          f;
    clk             = 1'b0;
    nreset          = 1'b0;
    proc_req        = 1'b0;
    proc_req_in0_en = 1'b0;
    proc_req_in1_en = 1'b0;
    in0_valid       = 1'b0;
    in0_data        = '0;
    in0_data_last   = 1'b0;
    in1_valid       = 1'b0;
    in1_data        = '0;
    in1_data_last   = 1'b0;
    out_ready       = 1'b0;
    cur_en          = 2'b00;
    frame_total     = 0;
    sent_cnt        = 0;
    ack_due         = 0;
    cycle_cnt       = 0;
    ready_always    = 1'b0;
    stim_state      = SEED;
    rdy_state       = xorshift32(~SEED);         // separate stream for out_ready
    test_name       = "reset";
    repeat (10) @(posedge clk);
    #1;
    nreset = 1'b1;
    repeat (2) @(posedge clk);
    check_bit("proc_ack after reset", 1'b0, proc_ack);
    check_bit("in0_ready after reset", 1'b0, in0_ready);
    check_bit("in1_ready after reset", 1'b0, in1_ready);
    check_bit("out_valid after reset", 1'b0, out_valid);

    for (f = 0; f < NUM_FRAMES; f++)
    begin
      test_name = $sformatf("frame %0d", f);
      draw_random(r);
      en = r[1:0];
      plan_frame(en, 1'b0);
      run_frame(en);
    end

    // both inputs streaming, no back-pressure
    test_name    = "directed";
    ready_always = 1'b1;
    plan_frame(2'b11, 1'b1);
    run_frame(2'b11);
    check_alternation();

    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== bench/merger_sva.sv ====
`timescale 1ns/1ps

module merger_sva
(
  input logic             clk,
  input logic             nreset,
  input logic             proc_req,
  input logic             proc_ack,
  input logic             in0_ready,
  input logic             in1_ready,
  input logic             out_valid,
  input logic             out_ready,
  input logic             out_data_last,
  input logic             out_data_source_id,
  input merge_pkg::data_t out_data
);

  // --------------------------------------------------
  // output channel
  // --------------------------------------------------
  // a stalled head word stays put until taken
  out_hold: assert property (@(posedge clk) disable iff (!nreset)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
      && $stable(out_data_last) && $stable(out_data_source_id))
    else $error("output word changed while out_ready was low");

  // --------------------------------------------------
  // request window
  // --------------------------------------------------
  ready_in_frame: assert property (@(posedge clk) disable iff (!nreset)
    (in0_ready || in1_ready) |-> proc_req)   // inputs only open inside a request
    else $error("input ready high without proc_req");

  ack_in_frame: assert property (@(posedge clk) disable iff (!nreset)
    $rose(proc_ack) |-> proc_req)
    else $error("proc_ack rose without proc_req");

endmodule

// ==== hdl/frame_merger.sv ====
`timescale 1ns/1ps
`include "merge_config.svh"

module frame_merger
(
  input  logic                         clk,
  input  logic                         nreset,
  // request / acknowledge
  input  logic                         proc_req,
  input  logic                         proc_req_in0_en,
  input  logic                         proc_req_in1_en,
  output logic                         proc_ack,
  // input 0
  input  logic                         in0_valid,
  output logic                         in0_ready,
  input  logic [`MERGE_DATA_WIDTH-1:0] in0_data,
  input  logic                         in0_data_last,
  // input 1
  input  logic                         in1_valid,
  output logic                         in1_ready,
  input  logic [`MERGE_DATA_WIDTH-1:0] in1_data,
  input  logic                         in1_data_last,
  // merged output
  output logic                         out_valid,
  input  logic                         out_ready,
  output logic [`MERGE_DATA_WIDTH-1:0] out_data,
  output logic                         out_data_source_id,
  output logic                         out_data_last
);

  logic start;                          // one cycle at frame start
  logic in0_en;
  logic in1_en;
  logic held0;
  logic held1;
  logic frame_done0;
  logic frame_done1;
  logic grant0;
  logic grant1;
  logic [`MERGE_DATA_WIDTH-1:0] word0;
  logic [`MERGE_DATA_WIDTH-1:0] word1;
  logic wr_en;
  logic wr_last;
  logic [`MERGE_DATA_WIDTH-1:0] wr_data;
  logic wr_src;
  logic full;

  // --------------------------------------------------
  // control
  // --------------------------------------------------
  frame_ctrl u_ctrl
  (
    .clk             (clk),
    .nreset          (nreset),
    .proc_req        (proc_req),
    .proc_req_in0_en (proc_req_in0_en),
    .proc_req_in1_en (proc_req_in1_en),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .out_data_last   (out_data_last),
    .start           (start),
    .in0_en          (in0_en),
    .in1_en          (in1_en),
    .proc_ack        (proc_ack)
  );

  // --------------------------------------------------
  // input stages
  // --------------------------------------------------
  // word_last is folded into frame_done inside each stage
  input_stage u_in0
  (
    .clk        (clk),
    .nreset     (nreset),
    .start      (start),
    .en         (in0_en),
    .grant      (grant0),
    .valid      (in0_valid),
    .data_last  (in0_data_last),
    .data       (in0_data),
    .ready      (in0_ready),
    .held       (held0),
    .word_last  (),
    .frame_done (frame_done0),
    .word       (word0)
  );

  input_stage u_in1
  (
    .clk        (clk),
    .nreset     (nreset),
    .start      (start),
    .en         (in1_en),
    .grant      (grant1),
    .valid      (in1_valid),
    .data_last  (in1_data_last),
    .data       (in1_data),
    .ready      (in1_ready),
    .held       (held1),
    .word_last  (),
    .frame_done (frame_done1),
    .word       (word1)
  );

  // --------------------------------------------------
  // arbitration and buffering
  // --------------------------------------------------
  rr_arbiter u_arb
  (
    .clk         (clk),
    .nreset      (nreset),
    .start       (start),
    .full        (full),
    .held0       (held0),
    .held1       (held1),
    .frame_done0 (frame_done0),
    .frame_done1 (frame_done1),
    .word0       (word0),
    .word1       (word1),
    .grant0      (grant0),
    .grant1      (grant1),
    .wr_en       (wr_en),
    .wr_last     (wr_last),
    .wr_data     (wr_data),
    .wr_src      (wr_src)
  );

  frame_fifo u_fifo
  (
    .clk                (clk),
    .nreset             (nreset),
    .start              (start),
    .wr_en              (wr_en),
    .wr_last            (wr_last),
    .out_ready          (out_ready),
    .wr_data            (wr_data),
    .wr_src             (wr_src),
    .full               (full),
    .out_valid          (out_valid),
    .out_data_last      (out_data_last),
    .out_data           (out_data),
    .out_data_source_id (out_data_source_id)
  );

endmodule

// ==== hdl/frame_fifo.sv ====
`timescale 1ns/1ps
`include "merge_config.svh"

module frame_fifo
(
  input  logic               clk,
  input  logic               nreset,
  input  logic               start,
  input  logic               wr_en,
  input  logic               wr_last,
  input  logic               out_ready,
  input  merge_pkg::data_t   wr_data,
  input  merge_pkg::src_id_t wr_src,
  output logic               full,
  output logic               out_valid,
  output logic               out_data_last,
  output merge_pkg::data_t   out_data,
  output merge_pkg::src_id_t out_data_source_id
);
  import merge_pkg::*;

  // storage, one entry per slot
  data_t       data_mem [`MERGE_FIFO_HEIGHT];
  logic        last_mem [`MERGE_FIFO_HEIGHT];
  src_id_t     src_mem  [`MERGE_FIFO_HEIGHT];

  fifo_ptr_t   wptr;
  fifo_ptr_t   rptr;
  fifo_level_t level;
  logic        empty;
  logic        rd_en;

  logic [FIFO_ADDR_WIDTH-1:0] waddr;
  logic [FIFO_ADDR_WIDTH-1:0] raddr;

  // --------------------------------------------------
  // pointers and level
  // --------------------------------------------------
  assign waddr = wptr[FIFO_ADDR_WIDTH-1:0];
  assign raddr = rptr[FIFO_ADDR_WIDTH-1:0];

  // power of two height, so plain increment wraps and flips the top bit
  always_ff @(posedge clk or negedge nreset)
  begin
    if (!nreset)
      wptr <= '0;
    else if (start)
      wptr <= '0;                    // new frame starts empty
    else if (wr_en)
      wptr <= wptr + 1'b1;
  end

  always_ff @(posedge clk or negedge nreset)
  begin
    if (!nreset)
      rptr <= '0;
    else if (start)
      rptr <= '0;
    else if (rd_en)
      rptr <= rptr + 1'b1;
  end

  // wrap bits differ with equal addresses when full
  assign level = wptr - rptr;
  assign full  = (level == fifo_level_t'(`MERGE_FIFO_HEIGHT));
  assign empty = (level == '0);

  // --------------------------------------------------
  // write side
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      data_mem[waddr] <= wr_data;
      last_mem[waddr] <= wr_last;
      src_mem[waddr]  <= wr_src;
    end
  end

  // --------------------------------------------------
  // read side
  // --------------------------------------------------
  assign out_valid = !empty;                 // head word shown combinationally
  assign rd_en     = out_valid && out_ready; // output handshake pops

  assign out_data           = data_mem[raddr];
  assign out_data_last      = last_mem[raddr];
  assign out_data_source_id = src_mem[raddr];

endmodule

// ==== hdl/rr_arbiter.sv ====
`timescale 1ns/1ps

module rr_arbiter
(
  input  logic              clk,
  input  logic              nreset,
  input  logic              start,
  input  logic              full,        // FIFO cannot take a word
  input  logic              held0,
  input  logic              held1,
  input  logic              frame_done0,
  input  logic              frame_done1,
  input  merge_pkg::data_t  word0,
  input  merge_pkg::data_t  word1,
  output logic              grant0,
  output logic              grant1,
  output logic              wr_en,
  output logic              wr_last,
  output merge_pkg::data_t  wr_data,
  output merge_pkg::src_id_t wr_src
);
  import merge_pkg::*;

  src_id_t last_grant; // input that won the previous grant

  // --------------------------------------------------
  // grant decision
  // --------------------------------------------------
  // a lone held word always wins, on a tie the other input goes first
  assign grant0 = !full && held0 && (last_grant == 1'b1 || !held1);
  assign grant1 = !full && held1 && (last_grant == 1'b0 || !held0);

  assign wr_en = grant0 || grant1;

  // --------------------------------------------------
  // write payload
  // --------------------------------------------------
  assign wr_data = grant0 ? word0 : word1;
  assign wr_src  = grant0 ? 1'b0 : 1'b1;

  // final word of the merged frame once both inputs are finished
  assign wr_last = frame_done0 && frame_done1;

  // --------------------------------------------------
  // round robin history
  // --------------------------------------------------
  always_ff @(posedge clk or negedge nreset)
  begin
    if (!nreset)
      last_grant <= 1'b0;
    else if (start)
      last_grant <= 1'b1;     // input 0 first in every frame
    else if (wr_en)
      last_grant <= wr_src;
  end

endmodule

// ==== hdl/input_stage.sv ====
`timescale 1ns/1ps

module input_stage
(
  input  logic            clk,
  input  logic            nreset,
  input  logic            start,      // frame start pulse
  input  logic            en,         // input takes part in this frame
  input  logic            grant,      // arbiter takes the held word now
  input  logic            valid,
  input  logic            data_last,
  input  merge_pkg::data_t data,
  output logic            ready,
  output logic            held,       // a word sits in the register
  output logic            word_last,  // last flag of the newest word, sticky
  output logic            frame_done,
  output merge_pkg::data_t word
);
  import merge_pkg::*;

  logic xfer;    // word accepted on this edge
  logic room;    // register free now or freed by the grant

  // --------------------------------------------------
  // input handshake
  // --------------------------------------------------
  assign room  = !held || grant;

  // no new words once the last one came in, and none in the start cycle
  assign ready = en && !start && !word_last && room;
  assign xfer  = ready && valid;

  // --------------------------------------------------
  // one word skid register
  // --------------------------------------------------
  always_ff @(posedge clk or negedge nreset)
  begin
    if (!nreset)
      held <= 1'b0;
    else if (room)
      held <= xfer;   // refill in the same cycle as a grant
  end

  always_ff @(posedge clk)
  begin
    if (xfer)
      word <= data;
  end

  // only written on transfers, so after the last word it stays high
  // and blocks the input until the next frame
  always_ff @(posedge clk or negedge nreset)
  begin
    if (!nreset)
      word_last <= 1'b0;
    else if (start)
      word_last <= 1'b0;
    else if (xfer)
      word_last <= data_last;
  end

  // --------------------------------------------------
  // completion
  // --------------------------------------------------
  // disabled input has nothing to send
  // enabled input is done once its last word is gone or going
  assign frame_done = !en || (word_last && room);

endmodule

// ==== hdl/frame_ctrl.sv ====
`timescale 1ns/1ps

module frame_ctrl
(
  input  logic clk,
  input  logic nreset,
  input  logic proc_req,
  input  logic proc_req_in0_en,
  input  logic proc_req_in1_en,
  input  logic out_valid,
  input  logic out_ready,
  input  logic out_data_last,
  output logic start,
  output logic in0_en,
  output logic in1_en,
  output logic proc_ack
);
  import merge_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  logic        req_prev;   // proc_req one cycle ago
  logic        last_sent;  // final word of the frame has left the output
  logic        frame_end;

  // --------------------------------------------------
  // frame start detection
  // --------------------------------------------------
  always_ff @(posedge clk or negedge nreset)
  begin
    if (!nreset)
      req_prev <= 1'b0;
    else
      req_prev <= proc_req;
  end

  assign start = proc_req && !req_prev; // first cycle of a request

  // enables sampled once per frame, stay put until the next start
  always_ff @(posedge clk or negedge nreset)
  begin
    if (!nreset)
    begin
      in0_en <= 1'b0;
      in1_en <= 1'b0;
    end
    else if (start)
    begin
      in0_en <= proc_req_in0_en;
      in1_en <= proc_req_in1_en;
    end
  end

  // --------------------------------------------------
  // end of frame tracking
  // --------------------------------------------------
  always_ff @(posedge clk or negedge nreset)
  begin
    if (!nreset)
      last_sent <= 1'b0;
    else if (start)
      last_sent <= 1'b0;                                   // new frame
    else if (out_valid && out_ready && out_data_last)
      last_sent <= 1'b1;
  end

  // a frame with no enabled input is finished right away
  assign frame_end = last_sent || (!in0_en && !in1_en);

  // --------------------------------------------------
  // control FSM
  // --------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      CTRL_IDLE: if (start)      state_nxt = CTRL_RUN;
      CTRL_RUN:  if (frame_end)  state_nxt = CTRL_ACK;
      CTRL_ACK:  if (!proc_req)  state_nxt = CTRL_IDLE; // host released
      default:                   state_nxt = CTRL_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge nreset)
  begin
    if (!nreset)
      state <= CTRL_IDLE;
    else
      state <= state_nxt;
  end

  assign proc_ack = (state == CTRL_ACK);

endmodule

// ==== hdl/merge_pkg.sv ====
`include "merge_config.svh"

package merge_pkg;

  // one data word
  typedef logic [`MERGE_DATA_WIDTH-1:0] data_t;

  typedef logic src_id_t;                       // 0 means input 0

  // address bits of the FIFO, the pointers carry one more for wrap
  localparam int FIFO_ADDR_WIDTH = $clog2(`MERGE_FIFO_HEIGHT);

  typedef logic [FIFO_ADDR_WIDTH:0] fifo_ptr_t;   // wrap bit on top
  typedef logic [FIFO_ADDR_WIDTH:0] fifo_level_t; // 0 .. height

  // request/acknowledge control
  typedef enum logic [1:0] {
    CTRL_IDLE, // waiting for proc_req
    CTRL_RUN,  // frame in progress
    CTRL_ACK   // proc_ack high until proc_req drops
  } ctrl_state_t;

endpackage

// ==== include/merge_config.svh ====
`ifndef MERGE_CONFIG_SVH
`define MERGE_CONFIG_SVH

// --------------------------------------------------
// frame merger sizing
// --------------------------------------------------

// bits per data word on every input and on the output
`define MERGE_DATA_WIDTH 8

// entries in the merge FIFO, power of two and at least 2
`define MERGE_FIFO_HEIGHT 4

`endif
